//--- compile.f
src/dcachePkg.sv
src/wayLookup.sv
src/dcacheController.sv
src/lineStore.sv
src/loadStoreData.sv
src/dcacheTop.sv
testbench/clockGen.sv
testbench/backingMemory.sv
testbench/dcacheTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Builds the cache testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
  --top-module dcacheTb -Mdir obj_dir -o dcacheSim -f compile.f

./obj_dir/dcacheSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation PASSED" sim.log; then
  exit 0
fi
exit 1

//--- src/dcacheController.sv
`timescale 1ns/10ps
`default_nettype none

module dcacheController #(
  parameter int setCount = 16,
  localparam int indexWidth = $clog2(setCount),
  localparam int tagWidth = 28 - indexWidth
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   flush,
  input  logic                   hit,
  input  logic                   victimDirty,
  input  logic                   busReady,
  input  dcachePkg::cpuReqT      cpuReq,
  input  dcachePkg::wayT         victimWay,
  input  dcachePkg::wayT         hitWay,
  input  logic [tagWidth-1:0]    victimTag,
  input  logic [1:0]             wayDirty,
  input  dcachePkg::wordT        lineWord,
  output logic                   stall,
  output logic                   flushDone,
  output logic                   wordWe,
  output logic                   fillSelect,
  output logic                   setDirty,
  output logic                   clearDirty,
  output logic                   touchLru,
  output dcachePkg::wayT         writeWay,
  output logic [indexWidth-1:0]  setIndex,
  output dcachePkg::wordOffsetT  wordOffset,
  output dcachePkg::busReqT      busReq
);
  import dcachePkg::*;

  typedef enum logic [2:0] {
    ready,
    writeBack,
    refill,
    flushScan,
    flushWrite
  } stateT;

  stateT                 state;
  stateT                 nextState;
  wordOffsetT            beatCount;
  logic [indexWidth-1:0] flushSet;
  logic                  requestActive;
  logic                  lastBeat;
  logic                  flushing;
  logic                  anyDirty;
  logic                  lastSet;

  assign requestActive = cpuReq.read | cpuReq.write;
  assign lastBeat = busReady & (beatCount == 2'd3);
  assign flushing = (state == flushScan) | (state == flushWrite);
  assign anyDirty = |wayDirty;
  assign lastSet = &flushSet;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= ready;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    unique case (state)
      ready: begin
        if (requestActive && !hit) begin
          nextState = victimDirty ? writeBack : refill;
        end else if (flush && !flushDone) begin
          // flushDone guards against restarting while flush is still seen high
          nextState = flushScan;
        end
      end
      writeBack: begin
        if (lastBeat) begin
          nextState = refill;
        end
      end
      refill: begin
        if (lastBeat) begin
          nextState = ready;
        end
      end
      flushScan: begin
        if (anyDirty) begin
          nextState = flushWrite;
        end else if (lastSet) begin
          nextState = ready;
        end
      end
      flushWrite: begin
        // Back to the same set, the other way may be dirty too
        if (lastBeat) begin
          nextState = flushScan;
        end
      end
      default: nextState = ready;
    endcase
  end

  // Beat counter wraps after four words, so every burst starts at zero
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      beatCount <= '0;
    end else if (busReq.request && busReady) begin
      beatCount <= beatCount + 2'd1;
    end
  end

  // Flush walk moves on once a set has no dirty way left
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      flushSet <= '0;
    end else if (state == ready) begin
      flushSet <= '0;
    end else if (state == flushScan && !anyDirty) begin
      flushSet <= flushSet + 1'b1;
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      flushDone <= 1'b0;
    end else begin
      flushDone <= (state == flushScan) & ~anyDirty & lastSet;
    end
  end

  assign stall = (state != ready) | (requestActive & ~hit);
  assign setIndex = flushing ? flushSet : cpuReq.addr[4 +: indexWidth];
  assign wordOffset = (state == ready) ? cpuReq.addr[3:2] : beatCount;

  always_comb begin
    wordWe = 1'b0;
    fillSelect = 1'b0;
    setDirty = 1'b0;
    clearDirty = 1'b0;
    touchLru = 1'b0;
    writeWay = victimWay;
    busReq = '0;
    unique case (state)
      ready: begin
        // Hit path, store lands at the next edge
        writeWay = hitWay;
        touchLru = requestActive & hit;
        wordWe = cpuReq.write & hit;
        setDirty = cpuReq.write & hit;
      end
      writeBack, flushWrite: begin
        busReq.request = 1'b1;
        busReq.write = 1'b1;
        busReq.addr = {victimTag, setIndex, beatCount, 2'b00};
        busReq.wData = lineWord;
        clearDirty = (state == flushWrite) & lastBeat;
      end
      refill: begin
        busReq.request = 1'b1;
        busReq.addr = {cpuReq.addr[31:4], beatCount, 2'b00};
        wordWe = busReady;
        fillSelect = 1'b1;
        // Last beat also writes the tag and marks the line valid and clean
        clearDirty = lastBeat;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- src/dcachePkg.sv
`default_nettype none

package dcachePkg;

  // Data word and byte address, same width on processor and bus sides
  typedef logic [31:0] wordT;
  typedef logic [31:0] addrT;

  // One write enable per byte lane
  typedef logic [3:0] byteMaskT;

  // Word within a four-word line
  typedef logic [1:0] wordOffsetT;

  // Way 0 or way 1
  typedef logic wayT;

  // Memory stage request, 70 bits
  typedef struct packed {
    logic     read;
    logic     write;
    addrT     addr;
    wordT     wData;
    byteMaskT byteMask;
  } cpuReqT;

  // One word beat on the memory bus, 66 bits
  typedef struct packed {
    logic request;
    logic write;
    addrT addr;
    wordT wData;
  } busReqT;

endpackage

`default_nettype wire

//--- src/dcacheTop.sv
`timescale 1ns/10ps
`default_nettype none

module dcacheTop #(
  parameter int setCount = 16,
  localparam int indexWidth = $clog2(setCount),
  localparam int tagWidth = 28 - indexWidth
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              flush,
  input  logic              busReady,
  input  dcachePkg::cpuReqT cpuReq,
  input  dcachePkg::wordT   busRData,
  output logic              stall,
  output logic              flushDone,
  output dcachePkg::wordT   rData,
  output dcachePkg::busReqT busReq
);
  import dcachePkg::*;

  logic                     hit;
  logic                     victimDirty;
  wayT                      hitWay;
  wayT                      victimWay;
  wayT                      writeWay;
  logic [tagWidth-1:0]      victimTag;
  logic [tagWidth-1:0]      fillTag;
  logic [1:0][tagWidth-1:0] wayTag;
  logic [1:0]               wayValid;
  logic [1:0]               wayDirty;
  logic                     lru;
  wordT [1:0]               wayWord;
  wordT                     lineWord;
  wordT                     storeWord;
  logic                     wordWe;
  logic                     fillSelect;
  logic                     setDirty;
  logic                     clearDirty;
  logic                     touchLru;
  logic [indexWidth-1:0]    setIndex;
  wordOffsetT               wordOffset;

  // Refilled line takes the tag of the request that missed
  assign fillTag = cpuReq.addr[31 -: tagWidth];

  // Way select, hit way in ready and the victim way during bursts
  assign lineWord = wayWord[writeWay];

  wayLookup #(
    .setCount(setCount)
  ) i_wayLookup (
    .clk        (clk),
    .reset      (reset),
    .cpuReq     (cpuReq),
    .wayTag     (wayTag),
    .wayValid   (wayValid),
    .wayDirty   (wayDirty),
    .lru        (lru),
    .hit        (hit),
    .victimDirty(victimDirty),
    .hitWay     (hitWay),
    .victimWay  (victimWay),
    .victimTag  (victimTag)
  );

  dcacheController #(
    .setCount(setCount)
  ) i_dcacheController (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .hit        (hit),
    .victimDirty(victimDirty),
    .busReady   (busReady),
    .cpuReq     (cpuReq),
    .victimWay  (victimWay),
    .hitWay     (hitWay),
    .victimTag  (victimTag),
    .wayDirty   (wayDirty),
    .lineWord   (lineWord),
    .stall      (stall),
    .flushDone  (flushDone),
    .wordWe     (wordWe),
    .fillSelect (fillSelect),
    .setDirty   (setDirty),
    .clearDirty (clearDirty),
    .touchLru   (touchLru),
    .writeWay   (writeWay),
    .setIndex   (setIndex),
    .wordOffset (wordOffset),
    .busReq     (busReq)
  );

  lineStore #(
    .setCount(setCount)
  ) i_lineStore (
    .clk       (clk),
    .reset     (reset),
    .wordWe    (wordWe),
    .fillSelect(fillSelect),
    .setDirty  (setDirty),
    .clearDirty(clearDirty),
    .touchLru  (touchLru),
    .writeWay  (writeWay),
    .setIndex  (setIndex),
    .wordOffset(wordOffset),
    .storeWord (storeWord),
    .busRData  (busRData),
    .fillTag   (fillTag),
    .wayTag    (wayTag),
    .wayValid  (wayValid),
    .wayDirty  (wayDirty),
    .lru       (lru),
    .wayWord   (wayWord)
  );

  loadStoreData i_loadStoreData (
    .cpuReq   (cpuReq),
    .lineWord (lineWord),
    .rData    (rData),
    .storeWord(storeWord)
  );

endmodule

`default_nettype wire

//--- src/lineStore.sv
`timescale 1ns/10ps
`default_nettype none

module lineStore #(
  parameter int setCount = 16,
  localparam int indexWidth = $clog2(setCount),
  localparam int tagWidth = 28 - indexWidth
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     wordWe,
  input  logic                     fillSelect,
  input  logic                     setDirty,
  input  logic                     clearDirty,
  input  logic                     touchLru,
  input  dcachePkg::wayT           writeWay,
  input  logic [indexWidth-1:0]    setIndex,
  input  dcachePkg::wordOffsetT    wordOffset,
  input  dcachePkg::wordT          storeWord,
  input  dcachePkg::wordT          busRData,
  input  logic [tagWidth-1:0]      fillTag,
  output logic [1:0][tagWidth-1:0] wayTag,
  output logic [1:0]               wayValid,
  output logic [1:0]               wayDirty,
  output logic                     lru,
  output dcachePkg::wordT [1:0]    wayWord
);
  import dcachePkg::*;

  wordT                     dataMem [2][setCount][4];
  logic [tagWidth-1:0]      tagMem [2][setCount];
  logic [1:0][setCount-1:0] validBits;
  logic [1:0][setCount-1:0] dirtyBits;
  logic [setCount-1:0]      lruBits;
  logic                     lineFill;

  // Final refill beat, recognized by the clean mark on a bus write
  assign lineFill = wordWe & fillSelect & clearDirty;

  always_ff @(posedge clk) begin
    if (wordWe) begin
      dataMem[writeWay][setIndex][wordOffset] <= fillSelect ? busRData : storeWord;
    end
    if (lineFill) begin
      tagMem[writeWay][setIndex] <= fillTag;
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
      lruBits <= '0;
    end else begin
      if (lineFill) begin
        validBits[writeWay][setIndex] <= 1'b1;
      end
      if (setDirty) begin
        dirtyBits[writeWay][setIndex] <= 1'b1;
      end else if (clearDirty) begin
        dirtyBits[writeWay][setIndex] <= 1'b0;
      end
      // LRU points at the way that was not used
      if (touchLru) begin
        lruBits[setIndex] <= ~writeWay;
      end
    end
  end

  // Read ports follow setIndex and wordOffset with no delay
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayTag[w] = tagMem[w][setIndex];
      wayValid[w] = validBits[w][setIndex];
      wayDirty[w] = dirtyBits[w][setIndex];
      wayWord[w] = dataMem[w][setIndex][wordOffset];
    end
  end

  assign lru = lruBits[setIndex];

endmodule

`default_nettype wire

//--- src/loadStoreData.sv
`timescale 1ns/10ps
`default_nettype none

module loadStoreData (
  input  dcachePkg::cpuReqT cpuReq,
  input  dcachePkg::wordT   lineWord,
  output dcachePkg::wordT   rData,
  output dcachePkg::wordT   storeWord
);

  // Loads are whole words, the processor picks its bytes
  assign rData = lineWord;

  // Byte lanes with the mask bit set come from the store data
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      if (cpuReq.byteMask[b]) begin
        storeWord[8*b +: 8] = cpuReq.wData[8*b +: 8];
      end else begin
        storeWord[8*b +: 8] = lineWord[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/wayLookup.sv
`timescale 1ns/10ps
`default_nettype none

module wayLookup #(
  parameter int setCount = 16,
  localparam int tagWidth = 28 - $clog2(setCount)
) (
  input  logic                     clk,
  input  logic                     reset,
  input  dcachePkg::cpuReqT        cpuReq,
  input  logic [1:0][tagWidth-1:0] wayTag,
  input  logic [1:0]               wayValid,
  input  logic [1:0]               wayDirty,
  input  logic                     lru,
  output logic                     hit,
  output logic                     victimDirty,
  output dcachePkg::wayT           hitWay,
  output dcachePkg::wayT           victimWay,
  output logic [tagWidth-1:0]      victimTag
);
  import dcachePkg::*;

  logic [tagWidth-1:0] reqTag;
  logic [1:0]          wayMatch;
  logic                requestActive;
  logic                missPending;
  wayT                 freshVictim;
  wayT                 heldVictim;

  // Tag sits above the set index and the 16-byte line offset
  assign reqTag = cpuReq.addr[31 -: tagWidth];
  assign requestActive = cpuReq.read | cpuReq.write;

  // Only valid ways can match
  assign wayMatch[0] = wayValid[0] & (wayTag[0] == reqTag);
  assign wayMatch[1] = wayValid[1] & (wayTag[1] == reqTag);
  assign hit = |wayMatch;
  assign hitWay = wayMatch[1];

  always_comb begin
    if (!requestActive && wayDirty[0]) begin
      // No request means the flush walk, which wants a dirty way
      freshVictim = 1'b0;
    end else if (!requestActive && wayDirty[1]) begin
      freshVictim = 1'b1;
    end else if (!wayValid[0]) begin
      freshVictim = 1'b0;
    end else if (!wayValid[1]) begin
      freshVictim = 1'b1;
    end else begin
      freshVictim = lru;
    end
  end

  // Victim is frozen from the first miss cycle until the request hits
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      missPending <= 1'b0;
    end else begin
      missPending <= requestActive & ~hit;
    end
  end

  always_ff @(posedge clk) begin
    if (!missPending) begin
      heldVictim <= freshVictim;
    end
  end

  assign victimWay = missPending ? heldVictim : freshVictim;
  assign victimDirty = wayDirty[victimWay];
  assign victimTag = wayTag[victimWay];

endmodule

`default_nettype wire

//--- testbench/backingMemory.sv
`timescale 1ns/10ps
`default_nettype none

module backingMemory #(
  parameter int wordCount = 1024,
  localparam int wordBits = $clog2(wordCount)
) (
  input  logic              clk,
  input  dcachePkg::busReqT busReq,
  input  dcachePkg::addrT   peekAddr,
  output logic              busReady,
  output dcachePkg::wordT   busRData,
  output dcachePkg::wordT   peekData
);
  import dcachePkg::*;

  wordT   mem [wordCount];
  busReqT reqSeen;
  int     seed;
  int     waitLeft;

  initial begin
    seed = 32'h2700;
    waitLeft = 0;
    reqSeen = '0;
    busReady = 1'b0;
    busRData = '0;
    // Each word starts as its own byte address with a marker in the upper half
    for (int i = 0; i < wordCount; i++) begin
      mem[i] = wordT'(i * 4) ^ 32'hA5A50000;
    end
  end

  // Bus request captured mid-cycle where it is stable
  always @(negedge clk) begin
    reqSeen = busReq;
  end

  always @(posedge clk) begin
    if (reqSeen.request && busReady) begin
      if (reqSeen.write) begin
        mem[reqSeen.addr[2 +: wordBits]] = reqSeen.wData;
      end
      // Next beat waits 0 to 3 cycles
      waitLeft = $random(seed) & 3;
    end
    #2;
    busReady = 1'b0;
    if (busReq.request) begin
      if (waitLeft == 0) begin
        busReady = 1'b1;
        busRData = mem[busReq.addr[2 +: wordBits]];
      end else begin
        waitLeft = waitLeft - 1;
      end
    end
  end

  assign peekData = mem[peekAddr[2 +: wordBits]];

endmodule

`default_nettype wire

//--- testbench/clockGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
  parameter int periodNs = 20,
  parameter int resetCycles = 3
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever begin
      #(periodNs / 2) clk = ~clk;
    end
  end

  // Reset drops just after a rising edge, like the rest of the stimulus
  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    #2;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/dcacheCases.txt
# op addr data mask expected beats, all in hex
# R read, W masked write, F flush, M memory check (mask is the line's written-back words)
# Read miss, then hits in the same line
R 00000020 00000000 0 A5A50020 4
R 00000020 00000000 0 A5A50020 0
R 0000002C 00000000 0 A5A5002C 0
# Byte-masked writes merge into one word
W 00000024 11223344 1 00000000 0
W 00000024 AABBCCDD 6 00000000 0
W 00000024 99887766 8 00000000 0
R 00000024 00000000 0 99BBCC44 0
# Three tags in set 1, dirty A is evicted by C
W 00000014 DEADBEEF F 00000000 4
R 00000114 00000000 0 A5A50114 4
R 00000214 00000000 0 A5A50214 8
M 00000014 00000000 F DEADBEEF 0
M 00000010 00000000 F A5A50010 0
# LRU order in set 3, B goes when C arrives
R 00000030 00000000 0 A5A50030 4
R 00000130 00000000 0 A5A50130 4
R 00000034 00000000 0 A5A50034 0
R 00000238 00000000 0 A5A50238 4
R 00000030 00000000 0 A5A50030 0
R 00000134 00000000 0 A5A50134 4
M 00000130 00000000 0 A5A50130 0
# Dirty lines in sets 2 and 15, then flush
W 000000F8 0BADF00D F 00000000 4
W 000001F4 12345678 3 00000000 4
F 00000000 00000000 0 00000000 C
M 00000024 00000000 F 99BBCC44 0
M 000000F8 00000000 F 0BADF00D 0
M 000001F4 00000000 F A5A55678 0
R 00000024 00000000 0 99BBCC44 0
R 000001F4 00000000 0 A5A55678 0
F 00000000 00000000 0 00000000 0

//--- testbench/dcacheTb.sv
`timescale 1ns/10ps
`default_nettype none

module dcacheTb;
  import dcachePkg::*;

  localparam int setCount = 16;
  localparam int memWords = 1024;
  localparam int cyclesPerCase = 200;
  localparam int clockPeriod = 20;

  typedef struct packed {
    logic [7:0] op;
    addrT       addr;
    wordT       data;
    byteMaskT   mask;
    wordT       expected;
    wordT       beats;
  } caseT;

  logic     clk;
  logic     reset;
  logic     flush;
  logic     busReady;
  logic     stall;
  logic     flushDone;
  cpuReqT   cpuReq;
  wordT     busRData;
  wordT     rData;
  busReqT   busReq;
  addrT     peekAddr;
  wordT     peekData;

  caseT     cases[$];
  wordT     refMem [memWords];
  byteMaskT lineWriteMask [memWords / 4];
  int       beatTotal;
  int       caseCount;
  logic     casesLoaded;

  clockGen #(
    .periodNs   (clockPeriod),
    .resetCycles(3)
  ) i_clockGen (
    .clk  (clk),
    .reset(reset)
  );

  backingMemory #(
    .wordCount(memWords)
  ) i_backingMemory (
    .clk     (clk),
    .busReq  (busReq),
    .peekAddr(peekAddr),
    .busReady(busReady),
    .busRData(busRData),
    .peekData(peekData)
  );

  dcacheTop #(
    .setCount(setCount)
  ) i_dcacheTop (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .busReady (busReady),
    .cpuReq   (cpuReq),
    .busRData (busRData),
    .stall    (stall),
    .flushDone(flushDone),
    .rData    (rData),
    .busReq   (busReq)
  );

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkWord(input string name, input wordT actual, input wordT expected);
    if (actual !== expected) begin
      stopWithFailure($sformatf("mismatch %s: got 0x%08h, expected 0x%08h",
                                name, actual, expected));
    end
  endtask

  task automatic checkMask(input string name, input byteMaskT actual,
                           input byteMaskT expected);
    if (actual !== expected) begin
      stopWithFailure($sformatf("mismatch %s: got 0x%h, expected 0x%h",
                                name, actual, expected));
    end
  endtask

  task automatic checkFlag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      stopWithFailure($sformatf("mismatch %s: got 0x%h, expected 0x%h",
                                name, actual, expected));
    end
  endtask

  task automatic loadCases();
    int         fd;
    int         fieldCount;
    string      lineText;
    caseT       entry;
    logic [7:0] op;
    addrT       addr;
    wordT       data;
    byteMaskT   mask;
    wordT       expected;
    wordT       beats;
    fd = $fopen("testbench/dcacheCases.txt", "r");
    if (fd == 0) begin
      stopWithFailure("could not open testbench/dcacheCases.txt");
    end
    while (!$feof(fd)) begin
      lineText = "";
      void'($fgets(lineText, fd));
      if (lineText.len() < 2 || lineText[0] == "#") begin
        continue;
      end
      fieldCount = $sscanf(lineText, "%c %h %h %h %h %h", op, addr, data, mask, expected, beats);
      if (fieldCount != 6) begin
        stopWithFailure({"badly formed line in the cases file: ", lineText});
      end
      entry.op = op;
      entry.addr = addr;
      entry.data = data;
      entry.mask = mask;
      entry.expected = expected;
      entry.beats = beats;
      cases.push_back(entry);
    end
    $fclose(fd);
  endtask

  // Byte lanes with the mask set take the new data
  task automatic mergeReference(input addrT addr, input wordT data, input byteMaskT mask);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        refMem[addr[11:2]][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  // Entered 2 ns after a rising edge, leaves at the same point
  task automatic runRequest(input cpuReqT req, output wordT data, output logic firstStall);
    cpuReq = req;
    @(negedge clk);
    firstStall = stall;
    while (stall) begin
      @(negedge clk);
    end
    data = rData;
    @(posedge clk);
    #2;
    cpuReq = '0;
  endtask

  task automatic runFlush();
    flush = 1'b1;
    @(negedge clk);
    while (!flushDone) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    // flushDone lasts a single cycle
    checkFlag("flushDone", flushDone, 1'b0);
    flush = 1'b0;
  endtask

  task automatic sweepMemory();
    for (int i = 0; i < memWords; i++) begin
      peekAddr = addrT'(i * 4);
      #1;
      checkWord($sformatf("memory[0x%03h]", i * 4), peekData, refMem[i]);
    end
  endtask

  task automatic inspectLine(input caseT c);
    peekAddr = c.addr;
    #1;
    checkWord("memory", peekData, c.expected);
    checkMask("lineWriteMask", lineWriteMask[c.addr[11:4]], c.mask);
  endtask

  // Count bus beats and note which words of each line were written back
  always @(negedge clk) begin
    if (busReq.request && busReady) begin
      beatTotal++;
      if (busReq.write) begin
        lineWriteMask[busReq.addr[11:4]][busReq.addr[3:2]] = 1'b1;
      end
    end
  end

  initial begin
    wait (casesLoaded);
    #(caseCount * cyclesPerCase * clockPeriod);
    stopWithFailure($sformatf("timeout: the cache hung, %0d cases did not finish in %0d cycles",
                              caseCount, caseCount * cyclesPerCase));
  end

  initial begin
    cpuReqT req;
    wordT   readData;
    logic   stalled;
    caseT   c;
    cpuReq = '0;
    flush = 1'b0;
    peekAddr = '0;
    beatTotal = 0;
    casesLoaded = 1'b0;
    for (int i = 0; i < memWords; i++) begin
      refMem[i] = wordT'(i * 4) ^ 32'hA5A50000;
    end
    for (int i = 0; i < memWords / 4; i++) begin
      lineWriteMask[i] = '0;
    end
    loadCases();
    caseCount = cases.size();
    casesLoaded = 1'b1;
    wait (!reset);
    foreach (cases[n]) begin
      c = cases[n];
      @(posedge clk);
      #2;
      beatTotal = 0;
      case (c.op)
        "R": begin
          req = '0;
          req.read = 1'b1;
          req.addr = c.addr;
          runRequest(req, readData, stalled);
          // A miss moves words on the bus and stalls its first cycle
          checkFlag("stall", stalled, c.beats != 0);
          checkWord("rData", readData, c.expected);
          checkWord("reference memory", refMem[c.addr[11:2]], c.expected);
        end
        "W": begin
          req = '0;
          req.write = 1'b1;
          req.addr = c.addr;
          req.wData = c.data;
          req.byteMask = c.mask;
          runRequest(req, readData, stalled);
          checkFlag("stall", stalled, c.beats != 0);
          mergeReference(c.addr, c.data, c.mask);
        end
        "F": begin
          runFlush();
          sweepMemory();
        end
        "M": begin
          inspectLine(c);
        end
        default: begin
          stopWithFailure($sformatf("unknown operation %c in the cases file", c.op));
        end
      endcase
      checkWord("bus beats", wordT'(beatTotal), c.beats);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
